//--- busPkg.sv
`default_nettype none

package busPkg;

    // Data bus and register width
    typedef logic [7:0] byteT;

    // Full 16-bit address
    typedef logic [15:0] addrT;

    // Program counter after reset
    localparam addrT RESET_PC = 16'h0200;

endpackage

`default_nettype wire

//--- ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    // Control flag bit positions
    localparam int SET_ADH_LOW = 0;
    localparam int SET_ADL_TO_DATA = 1;
    localparam int LOAD_ABL = 2;
    localparam int LOAD_ABH = 3;
    localparam int PC_INC = 4;
    localparam int PC_INC_PAIR = 5;
    localparam int SET_ADL_TO_PCL = 6;
    localparam int SET_ADH_TO_PCH = 7;
    localparam int SET_DB_TO_DATA = 8;
    localparam int SET_INPUT_B_TO_DB = 9;
    localparam int SET_SB_TO_DB = 10;
    localparam int SET_ADL_TO_ALU = 11;
    localparam int SET_ADH_TO_SB = 12;
    localparam int SET_INPUT_A_TO_SB = 13;
    localparam int SET_SB_TO_X = 14;
    localparam int SET_SB_TO_Y = 15;
    localparam int SET_SB_TO_ALU = 16;
    localparam int ALU_ADD = 17;
    localparam int ALU_ADD_CARRY = 18;
    localparam int LATCH_OP_PC = 19;
    localparam int EMIT_ADDR = 20;

    localparam int NUM_FLAGS = 21;

    typedef logic [NUM_FLAGS-1:0] ctrlFlagsT;

    typedef enum logic [2:0] {
        modeImplied,
        modeImmediate,
        modeZpg,
        modeZpgX,
        modeAbs,
        modeAbsX,
        modeAbsY
    } addrModeT;

    // Micro-steps of one addressing mode
    typedef enum logic [1:0] {
        A0,
        A1,
        A2
    } stepT;

    localparam busPkg::byteT OP_LDA_IMM = 8'hA9;
    localparam busPkg::byteT OP_LDA_ZPG = 8'hA5;
    localparam busPkg::byteT OP_LDA_ZPGX = 8'hB5;
    localparam busPkg::byteT OP_LDA_ABS = 8'hAD;
    localparam busPkg::byteT OP_LDA_ABSX = 8'hBD;
    localparam busPkg::byteT OP_LDA_ABSY = 8'hB9;
    localparam busPkg::byteT OP_NOP = 8'hEA;

endpackage

`default_nettype wire

//--- instBuffer.sv
`timescale 1ns/1ns
`default_nettype none

module instBuffer #(
    parameter int INST_DEPTH = 4
) (
    input  wire logic         clk,
    input  wire logic         rstN,
    input  wire logic         instValid,
    input  wire busPkg::byteT opCode,
    input  wire busPkg::byteT operandLo,
    input  wire busPkg::byteT operandHi,
    output logic              instCredit,
    output logic              bufValid,
    output busPkg::byteT      bufOpCode,
    output busPkg::byteT      bufLo,
    output busPkg::byteT      bufHi,
    input  wire logic         bufPop
);

    localparam int PTR_W = $clog2(INST_DEPTH);
    localparam int CNT_W = $clog2(INST_DEPTH + 1);

    busPkg::byteT opMem [INST_DEPTH];
    busPkg::byteT loMem [INST_DEPTH];
    busPkg::byteT hiMem [INST_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;

    assign bufValid = (count != '0);
    assign bufOpCode = opMem[rdPtr];
    assign bufLo = loMem[rdPtr];
    assign bufHi = hiMem[rdPtr];

    always_ff @(posedge clk) begin
        if (instValid) begin
            opMem[wrPtr] <= opCode;
            loMem[wrPtr] <= operandLo;
            hiMem[wrPtr] <= operandHi;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            instCredit <= 1'b0;
        end else begin
            if (instValid) begin
                wrPtr <= (wrPtr == PTR_W'(INST_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (bufPop) begin
                rdPtr <= (rdPtr == PTR_W'(INST_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + CNT_W'(instValid) - CNT_W'(bufPop);
            // One credit back per popped entry
            instCredit <= bufPop;
        end
    end

    // Upstream overran its credits
    noOverrun: assert property (@(posedge clk) disable iff (!rstN)
        instValid |-> (count != CNT_W'(INST_DEPTH)) || bufPop);

endmodule

`default_nettype wire

//--- addrModeFlags.sv
`timescale 1ns/1ns
`default_nettype none

module addrModeFlags (
    input  wire busPkg::byteT   opCode,
    input  wire ctrlPkg::stepT  step,
    output ctrlPkg::ctrlFlagsT  flags,
    output logic                lastStep
);

    ctrlPkg::addrModeT mode;

    always_comb begin
        case (opCode)
            ctrlPkg::OP_LDA_IMM:  mode = ctrlPkg::modeImmediate;
            ctrlPkg::OP_LDA_ZPG:  mode = ctrlPkg::modeZpg;
            ctrlPkg::OP_LDA_ZPGX: mode = ctrlPkg::modeZpgX;
            ctrlPkg::OP_LDA_ABS:  mode = ctrlPkg::modeAbs;
            ctrlPkg::OP_LDA_ABSX: mode = ctrlPkg::modeAbsX;
            ctrlPkg::OP_LDA_ABSY: mode = ctrlPkg::modeAbsY;
            default:              mode = ctrlPkg::modeImplied;
        endcase
    end

    always_comb begin
        flags = '0;
        lastStep = 1'b0;
        if (step == ctrlPkg::A0) begin
            flags[ctrlPkg::LATCH_OP_PC] = 1'b1;
        end
        case (mode)
            ctrlPkg::modeZpg: begin
                // Operand straight onto page zero
                flags[ctrlPkg::PC_INC_PAIR] = 1'b1;
                flags[ctrlPkg::SET_ADH_LOW] = 1'b1;
                flags[ctrlPkg::SET_ADL_TO_DATA] = 1'b1;
                flags[ctrlPkg::LOAD_ABL] = 1'b1;
                flags[ctrlPkg::LOAD_ABH] = 1'b1;
                flags[ctrlPkg::EMIT_ADDR] = 1'b1;
                lastStep = 1'b1;
            end
            ctrlPkg::modeZpgX: begin
                if (step == ctrlPkg::A0) begin
                    flags[ctrlPkg::PC_INC_PAIR] = 1'b1;
                    flags[ctrlPkg::SET_DB_TO_DATA] = 1'b1;
                    flags[ctrlPkg::SET_INPUT_B_TO_DB] = 1'b1;
                    flags[ctrlPkg::SET_SB_TO_X] = 1'b1;
                    flags[ctrlPkg::SET_INPUT_A_TO_SB] = 1'b1;
                    flags[ctrlPkg::ALU_ADD] = 1'b1;
                end else begin
                    // Sum wraps inside page zero
                    flags[ctrlPkg::SET_ADH_LOW] = 1'b1;
                    flags[ctrlPkg::SET_ADL_TO_ALU] = 1'b1;
                    flags[ctrlPkg::LOAD_ABL] = 1'b1;
                    flags[ctrlPkg::LOAD_ABH] = 1'b1;
                    flags[ctrlPkg::EMIT_ADDR] = 1'b1;
                    lastStep = 1'b1;
                end
            end
            ctrlPkg::modeAbs, ctrlPkg::modeAbsX, ctrlPkg::modeAbsY: begin
                if (step == ctrlPkg::A0) begin
                    flags[ctrlPkg::PC_INC] = 1'b1;
                    flags[ctrlPkg::SET_ADL_TO_PCL] = 1'b1;
                    flags[ctrlPkg::SET_ADH_TO_PCH] = 1'b1;
                    flags[ctrlPkg::LOAD_ABL] = 1'b1;
                    flags[ctrlPkg::LOAD_ABH] = 1'b1;
                    // Low operand plus index, or plus zero for plain absolute
                    flags[ctrlPkg::SET_DB_TO_DATA] = 1'b1;
                    flags[ctrlPkg::SET_INPUT_B_TO_DB] = 1'b1;
                    flags[ctrlPkg::SET_SB_TO_X] = (mode == ctrlPkg::modeAbsX);
                    flags[ctrlPkg::SET_SB_TO_Y] = (mode == ctrlPkg::modeAbsY);
                    flags[ctrlPkg::SET_INPUT_A_TO_SB] = (mode != ctrlPkg::modeAbs);
                    flags[ctrlPkg::ALU_ADD] = 1'b1;
                end else if (step == ctrlPkg::A1) begin
                    flags[ctrlPkg::PC_INC_PAIR] = 1'b1;
                    flags[ctrlPkg::SET_ADL_TO_ALU] = 1'b1;
                    flags[ctrlPkg::LOAD_ABL] = 1'b1;
                    flags[ctrlPkg::SET_DB_TO_DATA] = 1'b1;
                    if (mode == ctrlPkg::modeAbs) begin
                        flags[ctrlPkg::SET_SB_TO_DB] = 1'b1;
                        flags[ctrlPkg::SET_ADH_TO_SB] = 1'b1;
                        flags[ctrlPkg::LOAD_ABH] = 1'b1;
                        flags[ctrlPkg::EMIT_ADDR] = 1'b1;
                        lastStep = 1'b1;
                    end else begin
                        // High operand plus the low byte carry
                        flags[ctrlPkg::SET_INPUT_B_TO_DB] = 1'b1;
                        flags[ctrlPkg::ALU_ADD_CARRY] = 1'b1;
                    end
                end else begin
                    flags[ctrlPkg::SET_SB_TO_ALU] = 1'b1;
                    flags[ctrlPkg::SET_ADH_TO_SB] = 1'b1;
                    flags[ctrlPkg::LOAD_ABH] = 1'b1;
                    flags[ctrlPkg::EMIT_ADDR] = 1'b1;
                    lastStep = 1'b1;
                end
            end
            default: begin
                // Implied and immediate only move the PC
                flags[ctrlPkg::PC_INC] = (mode == ctrlPkg::modeImplied);
                flags[ctrlPkg::PC_INC_PAIR] = (mode == ctrlPkg::modeImmediate);
                flags[ctrlPkg::SET_ADL_TO_PCL] = 1'b1;
                flags[ctrlPkg::SET_ADH_TO_PCH] = 1'b1;
                flags[ctrlPkg::LOAD_ABL] = 1'b1;
                flags[ctrlPkg::LOAD_ABH] = 1'b1;
                lastStep = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- stepSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module stepSequencer (
    input  wire logic         clk,
    input  wire logic         rstN,
    input  wire logic         bufValid,
    input  wire busPkg::byteT bufOpCode,
    input  wire busPkg::byteT bufLo,
    input  wire busPkg::byteT bufHi,
    output logic              bufPop,
    input  wire logic         creditAvail,
    output ctrlPkg::ctrlFlagsT flags,
    output logic              stepActive,
    output busPkg::byteT      opData
);

    ctrlPkg::stepT step;
    ctrlPkg::ctrlFlagsT rawFlags;
    busPkg::byteT curOpCode;
    busPkg::byteT opReg;
    busPkg::byteT hiReg;
    logic lastStep;
    logic stall;
    logic advance;

    // A0 runs on the buffer head, later steps on the held copy
    assign curOpCode = (step == ctrlPkg::A0) ? bufOpCode : opReg;
    assign opData = (step == ctrlPkg::A0) ? bufLo : hiReg;

    addrModeFlags decode0 (
        .opCode   (curOpCode),
        .step     (step),
        .flags    (rawFlags),
        .lastStep (lastStep)
    );

    assign stepActive = (step != ctrlPkg::A0) || bufValid;
    assign stall = rawFlags[ctrlPkg::EMIT_ADDR] && !creditAvail;
    assign advance = stepActive && !stall;
    assign bufPop = (step == ctrlPkg::A0) && bufValid && !stall;
    assign flags = advance ? rawFlags : '0;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            step <= ctrlPkg::A0;
        end else if (advance) begin
            if (lastStep) begin
                step <= ctrlPkg::A0;
            end else begin
                step <= ctrlPkg::stepT'(step + 1'b1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bufPop) begin
            opReg <= bufOpCode;
            hiReg <= bufHi;
        end
    end

    stepInRange: assert property (@(posedge clk) disable iff (!rstN)
        step <= ctrlPkg::A2);

endmodule

`default_nettype wire

//--- addrDatapath.sv
`timescale 1ns/1ns
`default_nettype none

module addrDatapath #(
    parameter busPkg::addrT RESET_PC = busPkg::RESET_PC
) (
    input  wire logic               clk,
    input  wire logic               rstN,
    input  wire ctrlPkg::ctrlFlagsT flags,
    input  wire logic               stepActive,
    input  wire busPkg::byteT       opData,
    input  wire logic               indexWrite,
    input  wire logic               indexSelY,
    input  wire busPkg::byteT       indexData,
    output busPkg::addrT            abOut,
    output busPkg::addrT            opPc,
    output logic                    addrDone
);

    busPkg::addrT pc;
    busPkg::byteT xReg;
    busPkg::byteT yReg;
    busPkg::byteT db;
    busPkg::byteT sb;
    busPkg::byteT adl;
    busPkg::byteT adh;
    busPkg::byteT inputA;
    busPkg::byteT inputB;
    busPkg::byteT aluReg;
    busPkg::byteT abl;
    busPkg::byteT abh;
    logic carryReg;
    logic [8:0] aluSum;

    assign db = flags[ctrlPkg::SET_DB_TO_DATA] ? opData : '0;

    always_comb begin
        if (flags[ctrlPkg::SET_SB_TO_X]) sb = xReg;
        else if (flags[ctrlPkg::SET_SB_TO_Y]) sb = yReg;
        else if (flags[ctrlPkg::SET_SB_TO_ALU]) sb = aluReg;
        else if (flags[ctrlPkg::SET_SB_TO_DB]) sb = db;
        else sb = '0;

        if (flags[ctrlPkg::SET_ADL_TO_DATA]) adl = opData;
        else if (flags[ctrlPkg::SET_ADL_TO_PCL]) adl = pc[7:0];
        else if (flags[ctrlPkg::SET_ADL_TO_ALU]) adl = aluReg;
        else adl = '0;

        // Zero page forces the high byte low
        if (flags[ctrlPkg::SET_ADH_LOW]) adh = '0;
        else if (flags[ctrlPkg::SET_ADH_TO_PCH]) adh = pc[15:8];
        else if (flags[ctrlPkg::SET_ADH_TO_SB]) adh = sb;
        else adh = '0;
    end

    assign inputA = flags[ctrlPkg::SET_INPUT_A_TO_SB] ? sb : '0;
    assign inputB = flags[ctrlPkg::SET_INPUT_B_TO_DB] ? db : '0;
    assign aluSum = {1'b0, inputA} + {1'b0, inputB}
                  + {8'd0, flags[ctrlPkg::ALU_ADD_CARRY] & carryReg};

    always_ff @(posedge clk) begin
        if (flags[ctrlPkg::ALU_ADD] || flags[ctrlPkg::ALU_ADD_CARRY]) begin
            aluReg <= aluSum[7:0];
            carryReg <= aluSum[8];
        end
        if (flags[ctrlPkg::LOAD_ABL]) abl <= adl;
        if (flags[ctrlPkg::LOAD_ABH]) abh <= adh;
        if (flags[ctrlPkg::LATCH_OP_PC]) opPc <= pc;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= RESET_PC;
            xReg <= '0;
            yReg <= '0;
            addrDone <= 1'b0;
        end else begin
            pc <= pc + {flags[ctrlPkg::PC_INC_PAIR], flags[ctrlPkg::PC_INC]};
            if (indexWrite && !indexSelY) xReg <= indexData;
            if (indexWrite && indexSelY) yReg <= indexData;
            // ABL/ABH settle one cycle after the emit step
            addrDone <= flags[ctrlPkg::EMIT_ADDR];
        end
    end

    assign abOut = {abh, abl};

    indexIdle: assert property (@(posedge clk) disable iff (!rstN)
        indexWrite |-> !stepActive);

endmodule

`default_nettype wire

//--- resultStage.sv
`timescale 1ns/1ns
`default_nettype none

module resultStage #(
    parameter int OUT_CREDITS = 2
) (
    input  wire logic         clk,
    input  wire logic         rstN,
    input  wire logic         emit,
    input  wire logic         eaCredit,
    input  wire logic         addrDone,
    input  wire busPkg::addrT abOut,
    input  wire busPkg::addrT opPc,
    output logic              creditAvail,
    output logic              eaValid,
    output busPkg::addrT      effAddr,
    output busPkg::addrT      eaPc
);

    localparam int CNT_W = $clog2(OUT_CREDITS + 1);

    logic [CNT_W-1:0] creditCount;

    assign creditAvail = (creditCount != '0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            creditCount <= CNT_W'(OUT_CREDITS);
            eaValid <= 1'b0;
        end else begin
            // Spend on emit, refill on each returned credit
            creditCount <= creditCount - CNT_W'(emit) + CNT_W'(eaCredit);
            eaValid <= addrDone;
        end
    end

    always_ff @(posedge clk) begin
        if (addrDone) begin
            effAddr <= abOut;
            eaPc <= opPc;
        end
    end

    noUnderflow: assert property (@(posedge clk) disable iff (!rstN)
        emit |-> creditCount != '0);

    noOverflow: assert property (@(posedge clk) disable iff (!rstN)
        creditCount <= CNT_W'(OUT_CREDITS));

endmodule

`default_nettype wire

//--- addrUnitTop.sv
`timescale 1ns/1ns
`default_nettype none

module addrUnitTop #(
    parameter int           INST_DEPTH = 4,
    parameter int           OUT_CREDITS = 2,
    parameter busPkg::addrT RESET_PC = busPkg::RESET_PC
) (
    input  wire logic         clk,
    input  wire logic         rstN,
    input  wire logic         instValid,
    input  wire busPkg::byteT opCode,
    input  wire busPkg::byteT operandLo,
    input  wire busPkg::byteT operandHi,
    output logic              instCredit,
    input  wire logic         indexWrite,
    input  wire logic         indexSelY,
    input  wire busPkg::byteT indexData,
    output logic              eaValid,
    output busPkg::addrT      effAddr,
    output busPkg::addrT      eaPc,
    input  wire logic         eaCredit
);

    logic bufValid;
    logic bufPop;
    busPkg::byteT bufOpCode;
    busPkg::byteT bufLo;
    busPkg::byteT bufHi;
    busPkg::byteT opData;
    ctrlPkg::ctrlFlagsT flags;
    logic stepActive;
    logic creditAvail;
    logic addrDone;
    busPkg::addrT abOut;
    busPkg::addrT opPc;

    instBuffer #(.INST_DEPTH(INST_DEPTH)) buffer0 (
        .clk        (clk),
        .rstN       (rstN),
        .instValid  (instValid),
        .opCode     (opCode),
        .operandLo  (operandLo),
        .operandHi  (operandHi),
        .instCredit (instCredit),
        .bufValid   (bufValid),
        .bufOpCode  (bufOpCode),
        .bufLo      (bufLo),
        .bufHi      (bufHi),
        .bufPop     (bufPop)
    );

    stepSequencer seq0 (
        .clk         (clk),
        .rstN        (rstN),
        .bufValid    (bufValid),
        .bufOpCode   (bufOpCode),
        .bufLo       (bufLo),
        .bufHi       (bufHi),
        .bufPop      (bufPop),
        .creditAvail (creditAvail),
        .flags       (flags),
        .stepActive  (stepActive),
        .opData      (opData)
    );

    addrDatapath #(.RESET_PC(RESET_PC)) datapath0 (
        .clk        (clk),
        .rstN       (rstN),
        .flags      (flags),
        .stepActive (stepActive),
        .opData     (opData),
        .indexWrite (indexWrite),
        .indexSelY  (indexSelY),
        .indexData  (indexData),
        .abOut      (abOut),
        .opPc       (opPc),
        .addrDone   (addrDone)
    );

    resultStage #(.OUT_CREDITS(OUT_CREDITS)) result0 (
        .clk         (clk),
        .rstN        (rstN),
        .emit        (flags[ctrlPkg::EMIT_ADDR]),
        .eaCredit    (eaCredit),
        .addrDone    (addrDone),
        .abOut       (abOut),
        .opPc        (opPc),
        .creditAvail (creditAvail),
        .eaValid     (eaValid),
        .effAddr     (effAddr),
        .eaPc        (eaPc)
    );

endmodule

`default_nettype wire

//--- addrUnitTb.sv
`timescale 1ns/1ns
`default_nettype none

module addrUnitTb;

    localparam int INST_DEPTH = 4;
    localparam int OUT_CREDITS = 2;
    localparam int TIMEOUT = 200;

    logic clk;
    logic rstN;
    logic instValid;
    busPkg::byteT opCode;
    busPkg::byteT operandLo;
    busPkg::byteT operandHi;
    logic instCredit;
    logic indexWrite;
    logic indexSelY;
    busPkg::byteT indexData;
    logic eaValid;
    busPkg::addrT effAddr;
    busPkg::addrT eaPc;
    logic eaCredit;

    // Reference model and flow control state
    busPkg::addrT expAddrQ[$];
    busPkg::addrT expPcQ[$];
    integer dueQ[$];
    busPkg::addrT modelPc;
    busPkg::addrT lastEaPc;
    busPkg::addrT expA;
    busPkg::addrT expP;
    busPkg::byteT modelX;
    busPkg::byteT modelY;
    integer inCredits;
    integer maxOutstanding;
    integer resultCount;
    integer memSent;
    integer cycleCount;
    integer creditDelay;
    integer valueErrors;
    integer otherErrors;
    integer seed;
    logic holdCredits;
    logic returnNow;
    logic timedOut;
    string curTest;

    addrUnitTop #(
        .INST_DEPTH  (INST_DEPTH),
        .OUT_CREDITS (OUT_CREDITS),
        .RESET_PC    (busPkg::RESET_PC)
    ) dut0 (
        .clk        (clk),
        .rstN       (rstN),
        .instValid  (instValid),
        .opCode     (opCode),
        .operandLo  (operandLo),
        .operandHi  (operandHi),
        .instCredit (instCredit),
        .indexWrite (indexWrite),
        .indexSelY  (indexSelY),
        .indexData  (indexData),
        .eaValid    (eaValid),
        .effAddr    (effAddr),
        .eaPc       (eaPc),
        .eaCredit   (eaCredit)
    );

    always #4 clk = ~clk;

    task automatic checkAddr(input string what, input busPkg::addrT expected,
                             input busPkg::addrT actual);
        if (actual !== expected) begin
            $display("ERR %s %s: expected %h, actual %h", curTest, what, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkCount(input string what, input integer expected, input integer actual);
        if (actual !== expected) begin
            $display("ERR %s %s: expected %0d, actual %0d", curTest, what, expected, actual);
            valueErrors++;
        end
    endtask

    // Outputs sampled at the rising edge, credit decision made here too
    always @(posedge clk) begin
        cycleCount++;
        returnNow = 1'b0;
        if (!holdCredits && dueQ.size() > 0 && dueQ[0] <= cycleCount) begin
            void'(dueQ.pop_front());
            returnNow = 1'b1;
        end
        if (rstN && instCredit) inCredits++;
        if (rstN && eaValid) begin
            resultCount++;
            lastEaPc = eaPc;
            dueQ.push_back(cycleCount + creditDelay);
            if (expAddrQ.size() == 0) begin
                $display("Result arrived in %s with no instruction expecting it", curTest);
                otherErrors++;
            end else begin
                expA = expAddrQ.pop_front();
                expP = expPcQ.pop_front();
                checkAddr("effAddr", expA, effAddr);
                checkAddr("eaPc", expP, eaPc);
            end
        end
    end

    always @(negedge clk) eaCredit = returnNow;

    function automatic integer instLength(input busPkg::byteT op);
        case (op)
            ctrlPkg::OP_LDA_IMM, ctrlPkg::OP_LDA_ZPG, ctrlPkg::OP_LDA_ZPGX: instLength = 2;
            ctrlPkg::OP_LDA_ABS, ctrlPkg::OP_LDA_ABSX, ctrlPkg::OP_LDA_ABSY: instLength = 3;
            default: instLength = 1;
        endcase
    endfunction

    function automatic logic isMemory(input busPkg::byteT op);
        isMemory = (op == ctrlPkg::OP_LDA_ZPG) || (op == ctrlPkg::OP_LDA_ZPGX)
                || (op == ctrlPkg::OP_LDA_ABS) || (op == ctrlPkg::OP_LDA_ABSX)
                || (op == ctrlPkg::OP_LDA_ABSY);
    endfunction

    function automatic busPkg::addrT expectAddr(input busPkg::byteT op, input busPkg::byteT lo,
                                                input busPkg::byteT hi);
        busPkg::byteT zpSum;
        begin
            // Zero page X wraps inside page zero
            zpSum = lo + modelX;
            case (op)
                ctrlPkg::OP_LDA_ZPG: expectAddr = {8'h00, lo};
                ctrlPkg::OP_LDA_ZPGX: expectAddr = {8'h00, zpSum};
                ctrlPkg::OP_LDA_ABSX: expectAddr = {hi, lo} + {8'h00, modelX};
                ctrlPkg::OP_LDA_ABSY: expectAddr = {hi, lo} + {8'h00, modelY};
                default: expectAddr = {hi, lo};
            endcase
        end
    endfunction

    function automatic busPkg::byteT randomByte();
        randomByte = busPkg::byteT'($random(seed));
    endfunction

    task automatic reportTimeout(input string what);
        $display("Timeout in %s while %s", curTest, what);
        otherErrors++;
        timedOut = 1'b1;
    endtask

    task automatic idleCycle;
        @(negedge clk);
        instValid = 1'b0;
    endtask

    task automatic driveBeat(input busPkg::byteT op, input busPkg::byteT lo,
                             input busPkg::byteT hi);
        instValid = 1'b1;
        opCode = op;
        operandLo = lo;
        operandHi = hi;
        inCredits--;
        if (INST_DEPTH - inCredits > maxOutstanding) maxOutstanding = INST_DEPTH - inCredits;
        if (isMemory(op)) begin
            expAddrQ.push_back(expectAddr(op, lo, hi));
            expPcQ.push_back(modelPc);
            memSent++;
        end
        modelPc = modelPc + busPkg::addrT'(instLength(op));
    endtask

    task automatic sendInst(input busPkg::byteT op, input busPkg::byteT lo,
                            input busPkg::byteT hi);
        integer cycles;
        begin
            cycles = 0;
            @(negedge clk);
            while (inCredits == 0 && !timedOut) begin
                instValid = 1'b0;
                cycles++;
                if (cycles > TIMEOUT) reportTimeout("waiting for an input credit");
                @(negedge clk);
            end
            if (!timedOut) driveBeat(op, lo, hi);
            else instValid = 1'b0;
        end
    endtask

    task automatic waitIdle;
        integer cycles;
        begin
            cycles = 0;
            idleCycle();
            while (!timedOut && (inCredits < INST_DEPTH || expAddrQ.size() != 0
                                 || dueQ.size() != 0)) begin
                cycles++;
                if (cycles > TIMEOUT) reportTimeout("waiting for the unit to drain");
                idleCycle();
            end
        end
    endtask

    task automatic waitResults(input integer count);
        integer cycles;
        begin
            cycles = 0;
            idleCycle();
            while (!timedOut && resultCount < count) begin
                cycles++;
                if (cycles > TIMEOUT) reportTimeout("waiting for results");
                idleCycle();
            end
        end
    endtask

    // Index registers only change while nothing is in flight
    task automatic setIndex(input logic selY, input busPkg::byteT value);
        waitIdle();
        @(negedge clk);
        indexWrite = 1'b1;
        indexSelY = selY;
        indexData = value;
        @(negedge clk);
        indexWrite = 1'b0;
        if (selY) modelY = value;
        else modelX = value;
    endtask

    task automatic doReset;
        @(negedge clk);
        rstN = 1'b0;
        instValid = 1'b0;
        indexWrite = 1'b0;
        repeat (2) @(negedge clk);
        rstN = 1'b1;
        inCredits = INST_DEPTH;
        modelPc = busPkg::RESET_PC;
        modelX = 8'h00;
        modelY = 8'h00;
        expAddrQ.delete();
        expPcQ.delete();
        dueQ.delete();
    endtask

    task automatic runZeroPageSet(input busPkg::byteT x);
        setIndex(1'b0, x);
        sendInst(ctrlPkg::OP_LDA_ZPG, x ^ 8'h5A, 8'h00);
        sendInst(ctrlPkg::OP_LDA_ZPGX, 8'h10, 8'h00);
        sendInst(ctrlPkg::OP_LDA_ZPGX, 8'hF8, 8'h00);
        // High operand byte is junk and must be ignored
        sendInst(ctrlPkg::OP_LDA_ZPGX, 8'h7F, 8'hCC);
    endtask

    task automatic testZeroPage;
        curTest = "testZeroPage";
        resultCount = 0;
        memSent = 0;
        runZeroPageSet(8'h00);
        runZeroPageSet(8'h05);
        runZeroPageSet(8'h80);
        runZeroPageSet(8'hF0);
        runZeroPageSet(8'hFF);
        waitIdle();
        checkCount("results", memSent, resultCount);
    endtask

    task automatic testAbsolute;
        integer i;
        begin
            curTest = "testAbsolute";
            resultCount = 0;
            memSent = 0;
            creditDelay = 3;
            setIndex(1'b0, 8'h01);
            sendInst(ctrlPkg::OP_LDA_ABSX, 8'hFF, 8'h12);
            setIndex(1'b1, 8'hFF);
            sendInst(ctrlPkg::OP_LDA_ABSY, 8'hFF, 8'hFF);
            sendInst(ctrlPkg::OP_LDA_ABS, 8'h34, 8'h12);
            for (i = 0; i < 6; i++) begin
                setIndex(1'b0, randomByte());
                setIndex(1'b1, randomByte());
                sendInst(ctrlPkg::OP_LDA_ABS, randomByte(), randomByte());
                sendInst(ctrlPkg::OP_LDA_ABSX, randomByte(), randomByte());
                sendInst(ctrlPkg::OP_LDA_ABSY, randomByte(), randomByte());
            end
            waitIdle();
            checkCount("results", memSent, resultCount);
            creditDelay = 0;
        end
    endtask

    task automatic testPassThrough;
        curTest = "testPassThrough";
        resultCount = 0;
        memSent = 0;
        sendInst(ctrlPkg::OP_LDA_IMM, 8'h11, 8'h00);
        sendInst(ctrlPkg::OP_LDA_ZPG, 8'h20, 8'h00);
        sendInst(ctrlPkg::OP_NOP, 8'h00, 8'h00);
        sendInst(8'h00, 8'h00, 8'h00);
        sendInst(ctrlPkg::OP_LDA_ABSX, 8'h40, 8'h30);
        sendInst(8'hFF, 8'h99, 8'h99);
        sendInst(ctrlPkg::OP_LDA_ABS, 8'h00, 8'h80);
        sendInst(ctrlPkg::OP_LDA_IMM, 8'h22, 8'h00);
        sendInst(ctrlPkg::OP_LDA_ZPGX, 8'h05, 8'h00);
        sendInst(ctrlPkg::OP_NOP, 8'h00, 8'h00);
        sendInst(ctrlPkg::OP_LDA_ZPG, 8'h66, 8'h00);
        waitIdle();
        checkCount("results", memSent, resultCount);
    endtask

    task automatic testOutputBackPressure;
        curTest = "testOutputBackPressure";
        resultCount = 0;
        memSent = 0;
        holdCredits = 1'b1;
        sendInst(ctrlPkg::OP_LDA_ZPG, 8'h33, 8'h00);
        sendInst(ctrlPkg::OP_LDA_ABSX, 8'hF0, 8'h40);
        sendInst(ctrlPkg::OP_LDA_ZPGX, 8'h44, 8'h00);
        sendInst(ctrlPkg::OP_LDA_ABS, 8'h78, 8'h56);
        sendInst(ctrlPkg::OP_LDA_ABSY, 8'h01, 8'h80);
        waitResults(OUT_CREDITS);
        // Window in which no further result may appear
        repeat (12) idleCycle();
        checkCount("results while held", OUT_CREDITS, resultCount);
        holdCredits = 1'b0;
        waitIdle();
        checkCount("results after release", memSent, resultCount);
    endtask

    task automatic testInputCredits;
        integer idle;
        integer sent;
        integer cycles;
        begin
            curTest = "testInputCredits";
            resultCount = 0;
            memSent = 0;
            maxOutstanding = 0;
            holdCredits = 1'b1;
            idle = 0;
            sent = 0;
            cycles = 0;
            while (idle < 8 && !timedOut) begin
                @(negedge clk);
                cycles++;
                if (cycles > TIMEOUT) reportTimeout("sending until credits ran out");
                if (inCredits > 0) begin
                    driveBeat(ctrlPkg::OP_LDA_ZPG, busPkg::byteT'(sent), 8'h00);
                    sent++;
                    idle = 0;
                end else begin
                    instValid = 1'b0;
                    idle++;
                end
            end
            checkCount("beats sent", INST_DEPTH + OUT_CREDITS, sent);
            checkCount("peak outstanding credits", INST_DEPTH, maxOutstanding);
            checkCount("results while held", OUT_CREDITS, resultCount);
            holdCredits = 1'b0;
            waitIdle();
            checkCount("credits back", INST_DEPTH, inCredits);
            checkCount("results", sent, resultCount);
        end
    endtask

    task automatic testResetState;
        curTest = "testResetState";
        // Reset lands while results are still stalled in the unit
        holdCredits = 1'b1;
        sendInst(ctrlPkg::OP_LDA_ZPG, 8'h21, 8'h00);
        sendInst(ctrlPkg::OP_LDA_ABS, 8'h43, 8'h65);
        sendInst(ctrlPkg::OP_LDA_ZPGX, 8'h87, 8'h00);
        doReset();
        holdCredits = 1'b0;
        resultCount = 0;
        memSent = 0;
        repeat (10) idleCycle();
        checkCount("results after reset", 0, resultCount);
        sendInst(ctrlPkg::OP_LDA_ZPGX, 8'h10, 8'h00);
        waitIdle();
        checkCount("results", 1, resultCount);
        checkAddr("eaPc after reset", busPkg::RESET_PC, lastEaPc);
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        instValid = 1'b0;
        opCode = 8'h00;
        operandLo = 8'h00;
        operandHi = 8'h00;
        indexWrite = 1'b0;
        indexSelY = 1'b0;
        indexData = 8'h00;
        eaCredit = 1'b0;
        seed = 33;
        cycleCount = 0;
        creditDelay = 0;
        valueErrors = 0;
        otherErrors = 0;
        resultCount = 0;
        memSent = 0;
        maxOutstanding = 0;
        inCredits = INST_DEPTH;
        holdCredits = 1'b0;
        returnNow = 1'b0;
        timedOut = 1'b0;
        curTest = "reset";
        doReset();
        testZeroPage();
        testAbsolute();
        testPassThrough();
        testOutputBackPressure();
        testInputCredits();
        testResetState();
        $display("Checks done: %0d value errors, %0d other errors", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
busPkg.sv
ctrlPkg.sv
instBuffer.sv
addrModeFlags.sv
stepSequencer.sv
addrDatapath.sv
resultStage.sv
addrUnitTop.sv
addrUnitTb.sv

//--- Bender.yml
package:
  name: addrUnit

sources:
  - busPkg.sv
  - ctrlPkg.sv
  - instBuffer.sv
  - addrModeFlags.sv
  - stepSequencer.sv
  - addrDatapath.sv
  - resultStage.sv
  - addrUnitTop.sv
  - target: test
    files:
      - addrUnitTb.sv
